// ==== Makefile ====
# Verilator flow for the out-of-order core

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/exec_units.sv ====
/* ALU, multiplier and CDB */
`timescale 1ns/1ps

module exec_units (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  ooo_pkg::issue_pkt_t alu_issue,
    input  ooo_pkg::issue_pkt_t mul_issue,
    output logic                alu_issue_ready,
    output logic                mul_issue_ready,
    output ooo_pkg::cdb_pkt_t   cdb
);

    localparam int LAST = ooo_pkg::MUL_LATENCY - 1;
    localparam int HALF = ooo_pkg::XLEN / 2;

    logic                          alu_valid;
    logic [ooo_pkg::ROB_TAG_W-1:0] alu_tag;
    logic [ooo_pkg::XLEN-1:0]      alu_value;
    logic [ooo_pkg::XLEN-1:0]      alu_result;
    logic                          alu_fire;
    logic                          mul_fire;
    logic [LAST:0]                 mul_valid;
    logic [ooo_pkg::ROB_TAG_W-1:0] mul_tag [ooo_pkg::MUL_LATENCY];
    logic [ooo_pkg::XLEN-1:0]      s1_a;
    logic [ooo_pkg::XLEN-1:0]      s1_b;
    logic [ooo_pkg::XLEN-1:0]      s2_lo;   // a * b[15:0]
    logic [ooo_pkg::XLEN-1:0]      s2_hi;   // a * b[31:16]
    logic [ooo_pkg::XLEN-1:0]      s3_prod;

    // Hold the ALU when the multiplier owns the next CDB slot
    assign alu_issue_ready = !mul_valid[LAST-1];
    assign mul_issue_ready = 1'b1; // Fully pipelined
    assign alu_fire        = alu_issue.valid && alu_issue_ready;
    assign mul_fire        = mul_issue.valid && mul_issue_ready;

    always_comb begin
        case (alu_issue.op)
            ooo_pkg::OP_ADD: alu_result = alu_issue.a + alu_issue.b;
            ooo_pkg::OP_SUB: alu_result = alu_issue.a - alu_issue.b;
            ooo_pkg::OP_XOR: alu_result = alu_issue.a ^ alu_issue.b;
            default:         alu_result = alu_issue.a;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else if (flush) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            alu_valid <= alu_fire;
            mul_valid <= {mul_valid[LAST-1:0], mul_fire};
        end
    end

    always_ff @(posedge clock) begin
        if (alu_fire) begin
            alu_tag   <= alu_issue.tag;
            alu_value <= alu_result;
        end
        mul_tag[0] <= mul_issue.tag;
        for (int i = 1; i < ooo_pkg::MUL_LATENCY; i++) begin
            mul_tag[i] <= mul_tag[i-1];
        end
        s1_a    <= mul_issue.a;
        s1_b    <= mul_issue.b;
        s2_lo   <= s1_a * s1_b[HALF-1:0];
        s2_hi   <= s1_a * s1_b[ooo_pkg::XLEN-1:HALF];
        s3_prod <= s2_lo + (s2_hi << HALF); // Low word of the product
    end

    always_comb begin
        if (mul_valid[LAST]) begin
            cdb = '{valid: 1'b1, tag: mul_tag[LAST], value: s3_prod};
        end else begin
            cdb = '{valid: alu_valid, tag: alu_tag, value: alu_value};
        end
    end

    a_cdb_one_src: assert property (@(posedge clock) disable iff (reset)
        !(alu_valid && mul_valid[LAST]));

endmodule

// ==== logic/ooo_core.sv ====
/* Out-of-order core top */
`timescale 1ns/1ps

module ooo_core (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   dispatch_valid,
    input  ooo_pkg::dispatch_pkt_t dispatch,
    output logic                   dispatch_ready,
    output ooo_pkg::commit_pkt_t   commit
);

    logic                          accept;
    logic                          is_li;
    logic                          is_mul;
    logic                          alu_free;
    logic                          mul_free;
    logic                          rob_full;
    logic [ooo_pkg::ROB_TAG_W-1:0] alloc_tag;
    logic [ooo_pkg::ROB_TAG_W-1:0] head_tag;
    logic [ooo_pkg::ROB_TAG_W-1:0] lookup_tag [2];
    logic [1:0]                    rob_done;
    logic [ooo_pkg::XLEN-1:0]      rob_value [2];
    ooo_pkg::rename_pkt_t          rename;
    ooo_pkg::cdb_pkt_t             cdb;
    ooo_pkg::issue_pkt_t           alu_issue;
    ooo_pkg::issue_pkt_t           mul_issue;
    logic                          alu_issue_ready;
    logic                          mul_issue_ready;

    assign is_li  = (dispatch.op == ooo_pkg::OP_LI);
    assign is_mul = (dispatch.op == ooo_pkg::OP_MUL);
    // LI skips the station, everything needs a ROB slot
    assign dispatch_ready = !flush && !rob_full && (is_li || (is_mul ? mul_free : alu_free));
    assign accept         = dispatch_valid && dispatch_ready;

    rename_table u_rename_table (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (accept),
        .dispatch       (dispatch),
        .alloc_tag      (alloc_tag),
        .rob_done       (rob_done),
        .rob_value      (rob_value),
        .lookup_tag     (lookup_tag),
        .rename         (rename),
        .cdb            (cdb),
        .commit         (commit),
        .head_tag       (head_tag)
    );

    reorder_buffer u_reorder_buffer (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .alloc_valid (accept),
        .alloc_rd    (dispatch.rd),
        .alloc_done  (is_li),
        .alloc_value (dispatch.imm),
        .alloc_tag   (alloc_tag),
        .full        (rob_full),
        .lookup_tag  (lookup_tag),
        .rob_done    (rob_done),
        .rob_value   (rob_value),
        .cdb         (cdb),
        .commit      (commit),
        .head_tag    (head_tag)
    );

    reservation_station u_reservation_station (
        .clock           (clock),
        .reset           (reset),
        .flush           (flush),
        .alloc_valid     (accept && !is_li),
        .alloc_op        (dispatch.op),
        .alloc_tag       (alloc_tag),
        .rename          (rename),
        .cdb             (cdb),
        .alu_free        (alu_free),
        .mul_free        (mul_free),
        .alu_issue       (alu_issue),
        .mul_issue       (mul_issue),
        .alu_issue_ready (alu_issue_ready),
        .mul_issue_ready (mul_issue_ready)
    );

    exec_units u_exec_units (
        .clock           (clock),
        .reset           (reset),
        .flush           (flush),
        .alu_issue       (alu_issue),
        .mul_issue       (mul_issue),
        .alu_issue_ready (alu_issue_ready),
        .mul_issue_ready (mul_issue_ready),
        .cdb             (cdb)
    );

endmodule

// ==== logic/ooo_pkg.sv ====
/* Out-of-order core shared types */
package ooo_pkg;

    localparam int NUM_ARCH_REGS = 8;
    localparam int REG_IDX_W     = 3;
    localparam int XLEN          = 32;
    localparam int ROB_DEPTH     = 8;
    localparam int ROB_TAG_W     = 3;
    localparam int NUM_RS        = 4;
    localparam int MUL_LATENCY   = 3;

    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_e;

    // Class of each station slot, fixed at build time
    localparam fu_e RS_FU_MAP [NUM_RS] = '{FU_ALU, FU_ALU, FU_MULT, FU_MULT};

    typedef struct packed {
        op_e                  op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [XLEN-1:0]      imm;
    } dispatch_pkt_t;

    typedef struct packed {
        logic                 ready; // Value is valid, tag is stale
        logic [ROB_TAG_W-1:0] tag;   // Producer ROB entry
        logic [XLEN-1:0]      value;
    } src_operand_t;

    typedef struct packed {
        src_operand_t a;
        src_operand_t b;
    } rename_pkt_t;

    typedef struct packed {
        logic                 valid; // Issue handshake valid
        op_e                  op;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
    } issue_pkt_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } cdb_pkt_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
    } commit_pkt_t;

endpackage

// ==== logic/rename_table.sv ====
/* Register rename table */
`timescale 1ns/1ps

module rename_table (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            dispatch_valid, // Accepted dispatch
    input  ooo_pkg::dispatch_pkt_t          dispatch,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]   alloc_tag,
    input  logic [1:0]                      rob_done,
    input  logic [ooo_pkg::XLEN-1:0]        rob_value [2],
    output logic [ooo_pkg::ROB_TAG_W-1:0]   lookup_tag [2],
    output ooo_pkg::rename_pkt_t            rename,
    input  ooo_pkg::cdb_pkt_t               cdb,
    input  ooo_pkg::commit_pkt_t            commit,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]   head_tag
);

    logic [ooo_pkg::XLEN-1:0]          regs [ooo_pkg::NUM_ARCH_REGS]; // Committed values
    logic [ooo_pkg::NUM_ARCH_REGS-1:0] pending;                       // Waiting on a ROB entry
    logic [ooo_pkg::ROB_TAG_W-1:0]     tag_q [ooo_pkg::NUM_ARCH_REGS];

    // Committed value, finished ROB entry, live CDB, else wait on tag
    function automatic ooo_pkg::src_operand_t read_src(
        input logic [ooo_pkg::REG_IDX_W-1:0] idx,
        input logic                          done,
        input logic [ooo_pkg::XLEN-1:0]      done_value
    );
        ooo_pkg::src_operand_t src;
        src.tag   = tag_q[idx];
        src.ready = 1'b1;
        if (!pending[idx]) begin
            src.value = regs[idx]; // Register 0 is never pending
        end else if (done) begin
            src.value = done_value;
        end else if (cdb.valid && cdb.tag == tag_q[idx]) begin
            src.value = cdb.value; // Same-cycle capture
        end else begin
            src.ready = 1'b0;
            src.value = '0;
        end
        return src;
    endfunction

    always_comb begin
        lookup_tag[0] = tag_q[dispatch.rs1];
        lookup_tag[1] = tag_q[dispatch.rs2];
        rename.a      = read_src(dispatch.rs1, rob_done[0], rob_value[0]);
        rename.b      = read_src(dispatch.rs2, rob_done[1], rob_value[1]);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit.valid) begin
                if (commit.rd != '0) regs[commit.rd] <= commit.value;
                // Only the newest producer releases the mapping
                if (tag_q[commit.rd] == head_tag) pending[commit.rd] <= 1'b0;
            end
            if (flush) begin
                pending <= '0; // Values survive, mappings do not
            end else if (dispatch_valid && dispatch.rd != '0) begin
                pending[dispatch.rd] <= 1'b1; // Wins over a same-cycle commit
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_valid) tag_q[dispatch.rd] <= alloc_tag;
    end

    // Register 0 is unmapped, so it always reads as a ready zero
    a_r0_unmapped: assert property (@(posedge clock) disable iff (reset)
        (dispatch.rs1 == '0) |-> (rename.a.ready && rename.a.value == '0));

endmodule

// ==== logic/reorder_buffer.sv ====
/* In-order reorder buffer */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            alloc_valid,
    input  logic [ooo_pkg::REG_IDX_W-1:0]   alloc_rd,
    input  logic                            alloc_done,  // LI completes at dispatch
    input  logic [ooo_pkg::XLEN-1:0]        alloc_value,
    output logic [ooo_pkg::ROB_TAG_W-1:0]   alloc_tag,
    output logic                            full,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]   lookup_tag [2],
    output logic [1:0]                      rob_done,
    output logic [ooo_pkg::XLEN-1:0]        rob_value [2],
    input  ooo_pkg::cdb_pkt_t               cdb,
    output ooo_pkg::commit_pkt_t            commit,
    output logic [ooo_pkg::ROB_TAG_W-1:0]   head_tag
);

    logic [ooo_pkg::REG_IDX_W-1:0] rd_q    [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::XLEN-1:0]      value_q [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_DEPTH-1:0] done_q;
    logic [ooo_pkg::ROB_TAG_W-1:0] head;
    logic [ooo_pkg::ROB_TAG_W-1:0] tail;
    logic [ooo_pkg::ROB_TAG_W:0]   count; // One extra bit for the full case
    logic [ooo_pkg::ROB_TAG_W-1:0] cdb_off;

    assign alloc_tag = tail;
    assign head_tag  = head;
    assign full      = (count == ooo_pkg::ROB_DEPTH);
    assign cdb_off   = cdb.tag - head; // Distance from head, wraps with the ring

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            rob_done[k]  = done_q[lookup_tag[k]];
            rob_value[k] = value_q[lookup_tag[k]];
        end
        commit.valid = (count != '0) && done_q[head]; // Head retires once done
        commit.rd    = rd_q[head];
        commit.value = value_q[head];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) tail <= tail + 1'b1;
            if (commit.valid) head <= head + 1'b1;
            count <= count + (ooo_pkg::ROB_TAG_W + 1)'(alloc_valid)
                           - (ooo_pkg::ROB_TAG_W + 1)'(commit.valid);
        end
    end

    always_ff @(posedge clock) begin
        if (cdb.valid) begin
            done_q[cdb.tag]  <= 1'b1;
            value_q[cdb.tag] <= cdb.value;
        end
        if (alloc_valid) begin
            rd_q[tail]    <= alloc_rd;
            done_q[tail]  <= alloc_done;
            value_q[tail] <= alloc_value;
        end
    end

    a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
        !(alloc_valid && full));

    // Results only return for live entries
    a_cdb_live: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> ({1'b0, cdb_off} < count));

endmodule

// ==== logic/reservation_station.sv ====
/* Tomasulo reservation station */
`timescale 1ns/1ps

module reservation_station (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            alloc_valid,
    input  ooo_pkg::op_e                    alloc_op,
    input  logic [ooo_pkg::ROB_TAG_W-1:0]   alloc_tag,
    input  ooo_pkg::rename_pkt_t            rename,
    input  ooo_pkg::cdb_pkt_t               cdb,
    output logic                            alu_free,
    output logic                            mul_free,
    output ooo_pkg::issue_pkt_t             alu_issue,
    output ooo_pkg::issue_pkt_t             mul_issue,
    input  logic                            alu_issue_ready,
    input  logic                            mul_issue_ready
);

    logic [ooo_pkg::NUM_RS-1:0]    busy;
    ooo_pkg::op_e                  op_q  [ooo_pkg::NUM_RS];
    logic [ooo_pkg::ROB_TAG_W-1:0] tag_q [ooo_pkg::NUM_RS];
    ooo_pkg::src_operand_t         a_q   [ooo_pkg::NUM_RS];
    ooo_pkg::src_operand_t         b_q   [ooo_pkg::NUM_RS];
    logic [ooo_pkg::ROB_TAG_W:0]   seq_q [ooo_pkg::NUM_RS]; // Dispatch sequence at alloc
    logic [ooo_pkg::ROB_TAG_W:0]   seq_ctr;
    logic [ooo_pkg::ROB_TAG_W:0]   age   [ooo_pkg::NUM_RS];
    logic [ooo_pkg::NUM_RS-1:0]    rdy;
    logic [ooo_pkg::NUM_RS-1:0]    fire;
    ooo_pkg::fu_e                  alloc_cls;
    int                            alloc_idx;
    int                            alu_idx;
    int                            mul_idx;

    // Oldest ready entry of one class, -1 when none
    function automatic int pick_oldest(input ooo_pkg::fu_e cls);
        int                          sel;
        logic [ooo_pkg::ROB_TAG_W:0] best;
        sel  = -1;
        best = '0;
        for (int i = 0; i < ooo_pkg::NUM_RS; i++) begin
            if (ooo_pkg::RS_FU_MAP[i] == cls && rdy[i] && (sel < 0 || age[i] > best)) begin
                sel  = i;
                best = age[i];
            end
        end
        return sel;
    endfunction

    function automatic ooo_pkg::issue_pkt_t make_issue(input int idx);
        ooo_pkg::issue_pkt_t pkt;
        pkt = '0;
        if (idx >= 0) begin
            pkt.valid = 1'b1;
            pkt.op    = op_q[idx];
            pkt.tag   = tag_q[idx];
            pkt.a     = a_q[idx].value;
            pkt.b     = b_q[idx].value;
        end
        return pkt;
    endfunction

    always_comb begin
        for (int i = 0; i < ooo_pkg::NUM_RS; i++) begin
            rdy[i] = busy[i] && a_q[i].ready && b_q[i].ready;
            age[i] = seq_ctr - seq_q[i]; // Bounded by ROB depth, so no wrap
        end
        alu_idx   = pick_oldest(ooo_pkg::FU_ALU);
        mul_idx   = pick_oldest(ooo_pkg::FU_MULT);
        alu_issue = make_issue(alu_idx);
        mul_issue = make_issue(mul_idx);
        for (int i = 0; i < ooo_pkg::NUM_RS; i++) begin
            fire[i] = (alu_issue.valid && alu_issue_ready && alu_idx == i)
                   || (mul_issue.valid && mul_issue_ready && mul_idx == i);
        end
    end

    // Lowest free slot of the needed class
    always_comb begin
        alloc_cls = (alloc_op == ooo_pkg::OP_MUL) ? ooo_pkg::FU_MULT : ooo_pkg::FU_ALU;
        alloc_idx = -1;
        alu_free  = 1'b0;
        mul_free  = 1'b0;
        for (int i = ooo_pkg::NUM_RS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                if (ooo_pkg::RS_FU_MAP[i] == ooo_pkg::FU_ALU) alu_free = 1'b1;
                else mul_free = 1'b1;
                if (ooo_pkg::RS_FU_MAP[i] == alloc_cls) alloc_idx = i;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy    <= '0;
            seq_ctr <= '0;
        end else if (flush) begin
            busy    <= '0;
            seq_ctr <= '0;
        end else begin
            for (int i = 0; i < ooo_pkg::NUM_RS; i++) begin
                if (fire[i]) busy[i] <= 1'b0; // Freed on the issue handshake
            end
            if (alloc_valid && alloc_idx >= 0) begin
                busy[alloc_idx] <= 1'b1;
                seq_ctr         <= seq_ctr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < ooo_pkg::NUM_RS; i++) begin
            if (!a_q[i].ready && cdb.valid && cdb.tag == a_q[i].tag) begin
                a_q[i].ready <= 1'b1; // Wakeup by tag match
                a_q[i].value <= cdb.value;
            end
            if (!b_q[i].ready && cdb.valid && cdb.tag == b_q[i].tag) begin
                b_q[i].ready <= 1'b1;
                b_q[i].value <= cdb.value;
            end
        end
        if (alloc_valid && alloc_idx >= 0) begin
            op_q[alloc_idx]  <= alloc_op;
            tag_q[alloc_idx] <= alloc_tag;
            a_q[alloc_idx]   <= rename.a; // Already holds any same-cycle CDB value
            b_q[alloc_idx]   <= rename.b;
            seq_q[alloc_idx] <= seq_ctr;
        end
    end

    for (genvar i = 0; i < ooo_pkg::NUM_RS; i++) begin : g_issue_chk
        a_issue_ready: assert property (@(posedge clock) disable iff (reset)
            fire[i] |-> busy[i] && a_q[i].ready && b_q[i].ready);
    end

endmodule

// ==== project.f ====
logic/ooo_pkg.sv
logic/rename_table.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/exec_units.sv
logic/ooo_core.sv
tb/ooo_core_tb.sv

// ==== tb/ooo_core_tb.sv ====
/* Out-of-order core testbench */
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int MAX_INSTR = 64;
    localparam int MAX_TESTS = 8;

    logic                   clock;
    logic                   reset;
    logic                   flush;
    logic                   dispatch_valid;
    ooo_pkg::dispatch_pkt_t dispatch;
    logic                   dispatch_ready;
    ooo_pkg::commit_pkt_t   commit;

    ooo_pkg::dispatch_pkt_t prog       [MAX_INSTR]; // Flat instruction list of all tests
    string                  test_name  [MAX_TESTS];
    int                     test_first [MAX_TESTS];
    int                     test_len   [MAX_TESTS];
    int                     test_flush [MAX_TESTS]; // Accepted count before flush, -1 none
    int                     n_instr;
    int                     n_tests;

    logic [ooo_pkg::XLEN-1:0] spec_regs [ooo_pkg::NUM_ARCH_REGS]; // Program-order view
    logic [ooo_pkg::XLEN-1:0] arch_regs [ooo_pkg::NUM_ARCH_REGS]; // Committed view
    ooo_pkg::commit_pkt_t     expq [$];                           // Expected commits

    logic [31:0] lfsr_state;
    int          cycles;
    int          limit;
    int          errors;
    int          checks;
    int          test_errors;
    int          test_commits;

    ooo_core u_ooo_core (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .commit         (commit)
    );

    always #10 clock = ~clock;

    // Watchdog
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: commits still outstanding after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'h8020_0003) : {1'b0, s[31:1]};
    endfunction

    // One LFSR step per immediate bit
    function automatic logic [ooo_pkg::XLEN-1:0] random_word();
        logic [ooo_pkg::XLEN-1:0] w;
        for (int i = 0; i < ooo_pkg::XLEN; i++) begin
            w[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    task automatic add_test(input string name, input int flush_at);
        test_name[n_tests]  = name;
        test_first[n_tests] = n_instr;
        test_len[n_tests]   = 0;
        test_flush[n_tests] = flush_at;
        n_tests++;
    endtask

    task automatic add_instr(input ooo_pkg::op_e opc, input int rd, input int rs1, input int rs2);
        prog[n_instr] = '{op: opc, rd: 3'(rd), rs1: 3'(rs1), rs2: 3'(rs2), imm: '0};
        test_len[n_tests-1]++;
        n_instr++;
    endtask

    task automatic build_table();
        add_test("alu_basic", -1);
        add_instr(ooo_pkg::OP_LI, 1, 0, 0);
        add_instr(ooo_pkg::OP_LI, 2, 0, 0);
        add_instr(ooo_pkg::OP_ADD, 3, 1, 2);
        add_instr(ooo_pkg::OP_SUB, 4, 1, 2);
        add_instr(ooo_pkg::OP_XOR, 5, 1, 2);
        add_instr(ooo_pkg::OP_ADD, 6, 2, 2);
        add_test("raw_chain", -1);          // Forwarding through ALU and MUL results
        add_instr(ooo_pkg::OP_MUL, 3, 1, 2);
        add_instr(ooo_pkg::OP_ADD, 4, 3, 1);
        add_instr(ooo_pkg::OP_MUL, 5, 4, 3);
        add_instr(ooo_pkg::OP_MUL, 6, 5, 5);
        add_instr(ooo_pkg::OP_MUL, 7, 1, 2); // Overlaps the chain in the pipeline
        add_instr(ooo_pkg::OP_SUB, 1, 7, 6);
        add_instr(ooo_pkg::OP_XOR, 2, 1, 5);
        add_test("reg_zero", -1);
        add_instr(ooo_pkg::OP_LI, 0, 0, 0);
        add_instr(ooo_pkg::OP_ADD, 0, 1, 2);
        add_instr(ooo_pkg::OP_MUL, 0, 3, 4);
        add_instr(ooo_pkg::OP_ADD, 3, 0, 1);
        add_instr(ooo_pkg::OP_XOR, 4, 0, 0);
        add_instr(ooo_pkg::OP_MUL, 5, 0, 2);
        add_test("mul_flood", -1);          // Fills both MULT slots
        add_instr(ooo_pkg::OP_MUL, 1, 1, 2);
        add_instr(ooo_pkg::OP_MUL, 2, 2, 3);
        add_instr(ooo_pkg::OP_MUL, 3, 1, 2);
        add_instr(ooo_pkg::OP_MUL, 4, 3, 3);
        add_instr(ooo_pkg::OP_MUL, 5, 4, 1);
        add_instr(ooo_pkg::OP_MUL, 6, 5, 2);
        add_instr(ooo_pkg::OP_MUL, 7, 6, 6);
        add_instr(ooo_pkg::OP_MUL, 1, 7, 3);
        add_test("alu_flood", -1);
        add_instr(ooo_pkg::OP_ADD, 1, 1, 2);
        add_instr(ooo_pkg::OP_SUB, 2, 1, 3);
        add_instr(ooo_pkg::OP_XOR, 3, 2, 1);
        add_instr(ooo_pkg::OP_ADD, 4, 3, 3);
        add_instr(ooo_pkg::OP_SUB, 5, 4, 1);
        add_instr(ooo_pkg::OP_XOR, 6, 5, 2);
        add_instr(ooo_pkg::OP_ADD, 7, 6, 4);
        add_instr(ooo_pkg::OP_SUB, 1, 7, 5);
        add_test("rob_fill", -1);           // Slow head, LIs pile up behind it
        add_instr(ooo_pkg::OP_MUL, 1, 2, 3);
        add_instr(ooo_pkg::OP_MUL, 2, 1, 1);
        for (int i = 0; i < 8; i++) begin
            add_instr(ooo_pkg::OP_LI, 3 + (i % 5), 0, 0);
        end
        add_instr(ooo_pkg::OP_ADD, 6, 1, 2);
        add_test("flush_mid", 4);
        add_instr(ooo_pkg::OP_LI, 1, 0, 0);
        add_instr(ooo_pkg::OP_LI, 2, 0, 0);
        add_instr(ooo_pkg::OP_MUL, 3, 1, 2);
        add_instr(ooo_pkg::OP_MUL, 4, 3, 3);
        add_instr(ooo_pkg::OP_ADD, 5, 4, 1); // First one after the flush
        add_instr(ooo_pkg::OP_ADD, 6, 3, 2);
        add_instr(ooo_pkg::OP_XOR, 7, 6, 1);
        add_test("flush_mul", 2);
        add_instr(ooo_pkg::OP_MUL, 1, 2, 2);
        add_instr(ooo_pkg::OP_LI, 2, 0, 0);
        add_instr(ooo_pkg::OP_ADD, 3, 1, 2);
        add_instr(ooo_pkg::OP_MUL, 4, 1, 1);
    endtask

    // Reference execution in program order
    task automatic model_dispatch(input ooo_pkg::dispatch_pkt_t d);
        logic [ooo_pkg::XLEN-1:0] a;
        logic [ooo_pkg::XLEN-1:0] b;
        logic [ooo_pkg::XLEN-1:0] r;
        a = spec_regs[d.rs1];
        b = spec_regs[d.rs2];
        case (d.op)
            ooo_pkg::OP_LI:  r = d.imm;
            ooo_pkg::OP_ADD: r = a + b;
            ooo_pkg::OP_SUB: r = a - b;
            ooo_pkg::OP_XOR: r = a ^ b;
            default:         r = a * b; // Low word of the product
        endcase
        expq.push_back('{valid: 1'b1, rd: d.rd, value: r});
        if (d.rd != 0) spec_regs[d.rd] = r;  // r0 stays zero
    endtask

    task automatic check_commit(input string name);
        ooo_pkg::commit_pkt_t e;
        if (commit.valid) begin
            test_commits++;
            checks++;
            if (expq.size() == 0) begin
                $display("%s: commit of r%0d with no instruction outstanding", name, commit.rd);
                test_errors++;
            end else begin
                e = expq.pop_front();
                if (commit.rd != e.rd || commit.value != e.value) begin
                    $display("MISMATCH %s: expected r%0d=%h, actual r%0d=%h",
                             name, e.rd, e.value, commit.rd, commit.value);
                    test_errors++;
                end
                if (e.rd != 0) arch_regs[e.rd] = e.value;
            end
        end
    endtask

    task automatic run_test(input int t);
        ooo_pkg::dispatch_pkt_t cur;
        int                     idx;
        int                     accepted;
        int                     idle;
        logic                   flushed;
        idx          = 0;
        accepted     = 0;
        idle         = 0;
        flushed      = 1'b0;
        test_errors  = 0;
        test_commits = 0;
        cur          = prog[test_first[t]];
        cur.imm      = random_word();
        while (idx < test_len[t]) begin
            flush          = 1'b0;
            dispatch_valid = 1'b1;
            dispatch       = cur;
            if (!flushed && accepted == test_flush[t]) begin
                flush          = 1'b1;
                dispatch_valid = 1'b0;
            end
            @(negedge clock);
            check_commit(test_name[t]);            // A commit in the flush cycle still retires
            if (flush) begin
                flushed   = 1'b1;
                expq.delete();
                spec_regs = arch_regs;             // Back to committed state
            end else if (dispatch_ready) begin
                model_dispatch(cur);
                accepted++;
                idx++;
                if (idx < test_len[t]) begin
                    cur     = prog[test_first[t] + idx];
                    cur.imm = random_word();
                end
            end
            @(posedge clock);
            #2;
        end
        dispatch_valid = 1'b0;
        flush          = 1'b0;
        // Drain, then quiet cycles to catch extra commits
        while (expq.size() != 0 || idle < 8) begin
            @(negedge clock);
            check_commit(test_name[t]);
            if (expq.size() == 0) idle++;
            @(posedge clock);
            #2;
        end
        errors += test_errors;
        $display("%s: %0d accepted, %0d commits, %0d errors",
                 test_name[t], accepted, test_commits, test_errors);
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        lfsr_state     = 32'hf7b8_b11f;
        cycles         = 0;
        errors         = 0;
        checks         = 0;
        n_instr        = 0;
        n_tests        = 0;
        for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
            spec_regs[i] = '0;
            arch_regs[i] = '0;
        end
        build_table();
        limit = 16 + 60 * n_instr;
        repeat (16) @(posedge clock);
        #2 reset = 1'b0;
        @(negedge clock);
        checks++;
        if (!dispatch_ready || commit.valid) begin
            $display("Core not idle after reset: dispatch_ready=%b commit.valid=%b",
                     dispatch_ready, commit.valid);
            errors++;
        end
        @(posedge clock);
        #2;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
